/* all.f */
logic/chunk_alu_pkg.sv
logic/carry_chain_unit.sv
logic/chunk_reduce_unit.sv
logic/alu_result_merge.sv
logic/chunk_alu_top.sv
dv/chunk_alu_tb.sv

/* Bender.yml */
package:
  name: chunk_alu

sources:
  - logic/chunk_alu_pkg.sv
  - logic/carry_chain_unit.sv
  - logic/chunk_reduce_unit.sv
  - logic/alu_result_merge.sv
  - logic/chunk_alu_top.sv
  - target: test
    files:
      - dv/chunk_alu_tb.sv

/* dv/chunk_alu_tb.sv */
// testbench for the chunked ripple-carry ALU top level
// drives held operands and an opcode, waits for the result to settle,
// then checks it against a word level reference model
// covers carries across every chunk, the reductions, the compares,
// random operations and a reset in the middle of a held operation
`timescale 1ns/1ps

module chunk_alu_tb;

    localparam int settle = chunk_alu_pkg::settle_cycles;
    localparam int chunk_w = chunk_alu_pkg::chunk_w;
    localparam int chunk_count = chunk_alu_pkg::chunk_count;
    // reset check, directed arith, reduce, compare, random, reset pair
    localparam int num_checks = 1 + 4 + 24 + 10 + 200 + 2;
    // every check costs one operation of settle + 2 cycles at most
    localparam int timeout_cycles = num_checks * (settle + 2) + 20;

    logic                          clk = 1'b0;
    logic                          rst;
    chunk_alu_pkg::alu_operands_t  operands;
    chunk_alu_pkg::alu_op_e        op;
    chunk_alu_pkg::alu_result_t    result;

    // expected result and the strobe for the compare process
    chunk_alu_pkg::alu_result_t    expected = '0;
    logic                          check_en = 1'b0;
    int                            check_count = 0;
    int                            cycle_count = 0;
    logic [31:0]                   lfsr_state = 32'he1cd79e9;

    chunk_alu_top dut (
        .clk      (clk),
        .rst      (rst),
        .operands (operands),
        .op       (op),
        .result   (result)
    );

    // 4 ns period
    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////

    // whole word math, wraps modulo 2**16
    function automatic chunk_alu_pkg::alu_result_t expected_result(
        input chunk_alu_pkg::alu_operands_t ops,
        input chunk_alu_pkg::alu_op_e code
    );
        chunk_alu_pkg::alu_result_t r;
        r = '0;
        case (code)
            chunk_alu_pkg::op_add:        r.data = ops.a + ops.b;
            chunk_alu_pkg::op_sub:        r.data = ops.a - ops.b;
            chunk_alu_pkg::op_and_reduce: r.flag = &ops.a;
            chunk_alu_pkg::op_or_reduce:  r.flag = |ops.a;
            chunk_alu_pkg::op_xor_reduce: r.flag = ^ops.a;
            chunk_alu_pkg::op_eq:         r.flag = (ops.a == ops.c);
            chunk_alu_pkg::op_neq:        r.flag = (ops.a != ops.c);
            default:                      r = '0;
        endcase
        return r;
    endfunction

    function automatic chunk_alu_pkg::alu_operands_t make_ops(
        input logic [15:0] a,
        input logic [15:0] b,
        input logic [15:0] c
    );
        chunk_alu_pkg::alu_operands_t ops;
        ops.a = a;
        ops.b = b;
        ops.c = c;
        return ops;
    endfunction

    // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_word(output logic [15:0] w);
        logic [31:0] bits;
        take_bits(16, bits);
        w = bits[15:0];
    endtask

    task automatic random_ops(output chunk_alu_pkg::alu_operands_t ops);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [31:0] sel;
        random_word(a);
        random_word(b);
        random_word(c);
        // half the time c copies a so that equal shows up often
        take_bits(1, sel);
        ops = make_ops(a, b, sel[0] ? a : c);
    endtask

    task automatic random_opcode(output chunk_alu_pkg::alu_op_e code);
        logic [31:0] bits;
        take_bits(8, bits);
        code = chunk_alu_pkg::alu_op_e'(bits[7:0] % 7);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        if (got !== want) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // hold one operation for settle + 1 edges, then ask for a compare
    task automatic run_op(input chunk_alu_pkg::alu_operands_t ops,
                          input chunk_alu_pkg::alu_op_e code);
        @(posedge clk);
        operands <= ops;
        op       <= code;
        check_en <= 1'b0;
        expected <= expected_result(ops, code);
        repeat (settle + 1) @(posedge clk);
        check_en <= 1'b1;
    endtask

    //////////////////////////////////////////////////
    // compare and timeout
    //////////////////////////////////////////////////

    // negedge sampling keeps clear of the posedge updates
    always @(negedge clk) begin
        if (check_en) begin
            check_value("result.data", result.data, expected.data);
            check_value("result.flag", {15'h0, result.flag}, {15'h0, expected.flag});
            check_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: the run went past %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        chunk_alu_pkg::alu_operands_t ops;
        chunk_alu_pkg::alu_op_e code;
        logic [15:0] a;
        logic [15:0] flip;

        rst      = 1'b1;
        operands = '0;
        op       = chunk_alu_pkg::op_add;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // result cleared by the last reset edge with nothing applied
        expected <= '0;
        check_en <= 1'b1;

        // carries and borrows through every chunk boundary
        run_op(make_ops(16'h0FFF, 16'h0001, 16'h0), chunk_alu_pkg::op_add);
        run_op(make_ops(16'hFFFF, 16'h0001, 16'h0), chunk_alu_pkg::op_add);
        run_op(make_ops(16'h1000, 16'h0001, 16'h0), chunk_alu_pkg::op_sub);
        run_op(make_ops(16'h0000, 16'h0001, 16'h0), chunk_alu_pkg::op_sub);

        // reductions over three directed words and five random ones
        for (int i = 0; i < 8; i++) begin
            if (i == 0) a = 16'hFFFF;
            else if (i == 1) a = 16'h0000;
            else if (i == 2) a = 16'h8000;
            else random_word(a);
            run_op(make_ops(a, 16'h0, 16'h0), chunk_alu_pkg::op_and_reduce);
            run_op(make_ops(a, 16'h0, 16'h0), chunk_alu_pkg::op_or_reduce);
            run_op(make_ops(a, 16'h0, 16'h0), chunk_alu_pkg::op_xor_reduce);
        end

        // compare with c equal to a and then one chunk off at a time
        random_word(a);
        run_op(make_ops(a, 16'h0, a), chunk_alu_pkg::op_eq);
        run_op(make_ops(a, 16'h0, a), chunk_alu_pkg::op_neq);
        for (int k = 0; k < chunk_count; k++) begin
            flip = 16'h1 << (k * chunk_w);
            run_op(make_ops(a, 16'h0, a ^ flip), chunk_alu_pkg::op_eq);
            run_op(make_ops(a, 16'h0, a ^ flip), chunk_alu_pkg::op_neq);
        end

        for (int n = 0; n < 200; n++) begin
            random_ops(ops);
            random_opcode(code);
            run_op(ops, code);
        end

        //////////////////////////////////////////////////
        // reset while an add is still rippling
        // the low chunk already reads 2, so only the reset gives zero
        @(posedge clk);
        operands <= make_ops(16'h0FFF, 16'h0003, 16'h0);
        op       <= chunk_alu_pkg::op_add;
        check_en <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        rst      <= 1'b0;
        expected <= '0;
        check_en <= 1'b1;
        run_op(make_ops(16'hF0F0, 16'h1F10, 16'h0), chunk_alu_pkg::op_add);

        // let the last compare happen before the verdict
        @(posedge clk);
        check_en <= 1'b0;
        @(negedge clk);
        if (check_count == num_checks) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("only %0d of %0d result checks ran", check_count, num_checks);
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* logic/chunk_alu_top.sv */
// top level of the chunked ripple-carry ALU
// hold operands and op steady for settle_cycles edges
// then result carries the answer for as long as they stay held
`timescale 1ns/1ps

module chunk_alu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  chunk_alu_pkg::alu_operands_t  operands,
    input  chunk_alu_pkg::alu_op_e        op,
    output chunk_alu_pkg::alu_result_t    result
);

    // sum and difference from the carry chain
    chunk_alu_pkg::arith_result_t arith;
    // reduce and compare flags
    chunk_alu_pkg::reduce_flags_t flags;

    //////////////////////////////////////////////////
    // parallel units on the same operands
    //////////////////////////////////////////////////

    // slowest path, settles after chunk_count - 1 edges
    carry_chain_unit u_carry_chain (
        .clk      (clk),
        .rst      (rst),
        .operands (operands),
        .arith    (arith)
    );

    // settles after one edge
    chunk_reduce_unit u_chunk_reduce (
        .clk      (clk),
        .rst      (rst),
        .operands (operands),
        .flags    (flags)
    );

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////

    // adds one more edge on top of the slowest unit
    alu_result_merge u_result_merge (
        .clk    (clk),
        .rst    (rst),
        .op     (op),
        .arith  (arith),
        .flags  (flags),
        .result (result)
    );

endmodule

/* logic/alu_result_merge.sv */
// picks the result for the held opcode and registers it
// add and sub give data with a zero flag
// the reduce opcodes give a flag with zero data
`timescale 1ns/1ps

module alu_result_merge (
    input  logic                          clk,
    input  logic                          rst,
    input  chunk_alu_pkg::alu_op_e        op,
    input  chunk_alu_pkg::arith_result_t  arith,
    input  chunk_alu_pkg::reduce_flags_t  flags,
    output chunk_alu_pkg::alu_result_t    result
);

    // selected result ahead of the register
    chunk_alu_pkg::alu_result_t result_d;

    //////////////////////////////////////////////////
    // opcode select
    //////////////////////////////////////////////////

    always_comb begin
        // zero unless the opcode fills a field
        result_d = '0;
        case (op)
            chunk_alu_pkg::op_add: begin
                result_d.data = arith.sum;
            end
            chunk_alu_pkg::op_sub: begin
                result_d.data = arith.diff;
            end
            chunk_alu_pkg::op_and_reduce: begin
                result_d.flag = flags.all_ones;
            end
            chunk_alu_pkg::op_or_reduce: begin
                result_d.flag = flags.any_one;
            end
            chunk_alu_pkg::op_xor_reduce: begin
                result_d.flag = flags.parity;
            end
            chunk_alu_pkg::op_eq: begin
                result_d.flag = flags.equal;
            end
            chunk_alu_pkg::op_neq: begin
                result_d.flag = flags.not_equal;
            end
            // unused encoding keeps the zero result
            default: begin
                result_d = '0;
            end
        endcase
    end

    // one edge behind the selected unit
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= result_d;
        end
    end

endmodule

/* logic/chunk_reduce_unit.sv */
// AND, OR and XOR reductions of operand a and the a against c compare
// each chunk registers its own flags and the word flags combine them
// word flags are correct one edge after the operands change
`timescale 1ns/1ps

module chunk_reduce_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  chunk_alu_pkg::alu_operands_t  operands,
    output chunk_alu_pkg::reduce_flags_t  flags
);

    localparam int chunk_w = chunk_alu_pkg::chunk_w;
    localparam int chunk_count = chunk_alu_pkg::chunk_count;

    // per chunk flags from the held operands
    logic [chunk_count-1:0] and_d;
    logic [chunk_count-1:0] or_d;
    logic [chunk_count-1:0] xor_d;
    logic [chunk_count-1:0] eq_d;

    // registered per chunk flags
    logic [chunk_count-1:0] and_q;
    logic [chunk_count-1:0] or_q;
    logic [chunk_count-1:0] xor_q;
    logic [chunk_count-1:0] eq_q;

    // word level equality, shared by equal and not_equal
    logic word_eq;

    //////////////////////////////////////////////////
    // chunk level reduction
    //////////////////////////////////////////////////

    for (genvar k = 0; k < chunk_count; k++) begin : g_chunk
        assign and_d[k] = &operands.a[k*chunk_w +: chunk_w];
        assign or_d[k]  = |operands.a[k*chunk_w +: chunk_w];
        assign xor_d[k] = ^operands.a[k*chunk_w +: chunk_w];
        // compare only this chunk of a and c
        assign eq_d[k]  = operands.a[k*chunk_w +: chunk_w]
                       == operands.c[k*chunk_w +: chunk_w];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            and_q <= '0;
            or_q  <= '0;
            xor_q <= '0;
            eq_q  <= '0;
        end else begin
            and_q <= and_d;
            or_q  <= or_d;
            xor_q <= xor_d;
            eq_q  <= eq_d;
        end
    end

    //////////////////////////////////////////////////
    // word level flags
    //////////////////////////////////////////////////

    // one combinational step over the chunk registers
    assign word_eq = &eq_q;

    assign flags.all_ones  = &and_q;
    assign flags.any_one   = |or_q;
    assign flags.parity    = ^xor_q;
    assign flags.equal     = word_eq;
    // not equal is simply the inverted equal
    assign flags.not_equal = ~word_eq;

endmodule

/* logic/carry_chain_unit.sv */
// chunked add and subtract of operands a and b
// a carry and a borrow register sit on every chunk boundary
// so the long carry path is broken into chunk sized steps
// operands must be held until the sum and difference settle
`timescale 1ns/1ps

module carry_chain_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  chunk_alu_pkg::alu_operands_t  operands,
    output chunk_alu_pkg::arith_result_t  arith
);

    localparam int chunk_w = chunk_alu_pkg::chunk_w;
    localparam int chunk_count = chunk_alu_pkg::chunk_count;

    // combinational results, one slice per chunk
    chunk_alu_pkg::word_t sum_w;
    chunk_alu_pkg::word_t diff_w;

    // chunk carry and borrow outs before the boundary register
    logic [chunk_count-2:0] carry_d;
    logic [chunk_count-2:0] borrow_d;

    // boundary registers, bit k feeds chunk k+1
    logic [chunk_count-2:0] carry_q;
    logic [chunk_count-2:0] borrow_q;

    // carry and borrow into each chunk
    logic [chunk_count-1:0] carry_in;
    logic [chunk_count-1:0] borrow_in;

    // lowest chunk has nothing coming in
    assign carry_in  = {carry_q, 1'b0};
    assign borrow_in = {borrow_q, 1'b0};

    //////////////////////////////////////////////////
    // per chunk arithmetic
    //////////////////////////////////////////////////

    for (genvar k = 0; k < chunk_count; k++) begin : g_chunk
        if (k < chunk_count - 1) begin : g_low
            // one extra bit catches the carry or borrow out
            logic [chunk_w:0] sum_ext;
            logic [chunk_w:0] diff_ext;

            assign sum_ext = {1'b0, operands.a[k*chunk_w +: chunk_w]}
                           + {1'b0, operands.b[k*chunk_w +: chunk_w]}
                           + {{chunk_w{1'b0}}, carry_in[k]};

            // msb goes high when the chunk result is negative
            assign diff_ext = {1'b0, operands.a[k*chunk_w +: chunk_w]}
                            - {1'b0, operands.b[k*chunk_w +: chunk_w]}
                            - {{chunk_w{1'b0}}, borrow_in[k]};

            assign sum_w[k*chunk_w +: chunk_w]  = sum_ext[chunk_w-1:0];
            assign diff_w[k*chunk_w +: chunk_w] = diff_ext[chunk_w-1:0];
            assign carry_d[k]  = sum_ext[chunk_w];
            assign borrow_d[k] = diff_ext[chunk_w];
        end else begin : g_top
            // top chunk wraps modulo 2**word_w
            assign sum_w[k*chunk_w +: chunk_w] = operands.a[k*chunk_w +: chunk_w]
                                               + operands.b[k*chunk_w +: chunk_w]
                                               + {{(chunk_w-1){1'b0}}, carry_in[k]};
            assign diff_w[k*chunk_w +: chunk_w] = operands.a[k*chunk_w +: chunk_w]
                                                - operands.b[k*chunk_w +: chunk_w]
                                                - {{(chunk_w-1){1'b0}}, borrow_in[k]};
        end
    end

    //////////////////////////////////////////////////
    // boundary registers
    //////////////////////////////////////////////////

    // load every clock
    // chunk k is right after k edges of held operands
    always_ff @(posedge clk) begin
        if (rst) begin
            carry_q  <= '0;
            borrow_q <= '0;
        end else begin
            carry_q  <= carry_d;
            borrow_q <= borrow_d;
        end
    end

    assign arith.sum  = sum_w;
    assign arith.diff = diff_w;

endmodule

/* logic/chunk_alu_pkg.sv */
// shared sizes and types for the chunked ripple-carry ALU
// the word is cut into equal chunks with one register per chunk boundary
// every RTL file and the testbench refer to these by scoped names
package chunk_alu_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // operand and result width
    localparam int word_w = 16;
    // width of one ripple chunk
    localparam int chunk_w = 4;
    // number of chunks in a word
    localparam int chunk_count = word_w / chunk_w;
    // edges from held inputs to a correct result
    localparam int settle_cycles = chunk_count;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [word_w-1:0] word_t;

    // a and b feed the adder, a and c feed the compare
    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } alu_operands_t;

    // opcode held as a level next to the operands
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and_reduce,
        op_or_reduce,
        op_xor_reduce,
        op_eq,
        op_neq
    } alu_op_e;

    // both arithmetic results settle side by side
    typedef struct packed {
        word_t sum;
        word_t diff;
    } arith_result_t;

    // word level flags from the reduction unit
    typedef struct packed {
        logic all_ones;
        logic any_one;
        logic parity;
        logic equal;
        logic not_equal;
    } reduce_flags_t;

    // data for add and sub, flag for the reduce opcodes
    typedef struct packed {
        word_t data;
        logic  flag;
    } alu_result_t;

endpackage
